// ==== all.f ====
+incdir+rtl
rtl/prbs_link_pkg.sv
rtl/ccb_cmd_decoder.sv
rtl/link_boot_sequencer.sv
rtl/prbs_error_monitor.sv
rtl/led_status_mux.sv
rtl/prbs_link_top.sv
sim/tb_prbs_link_top.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_prbs_link_top
FILELIST  = all.f
LOG       = sim.log

.PHONY: sim clean

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== sim/tb_prbs_link_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "prbs_link_defines.svh"

module tb_prbs_link_top
    import prbs_link_pkg::*;
();

    localparam lane_vec_t ALL_LANES    = '1;
    localparam int        MAX_XCVR_DLY = 15;
    localparam int        ERR_ROUNDS   = 70;
    localparam int        INJECT_STEPS = 24;
    // Worst boot: two timed steps with their acks, then the inject window
    localparam int BOOT_MAX_CYC = 2 + 2 * (`SETTLE_TICKS * `BOOT_TICK_DIV + MAX_XCVR_DLY + 3)
                                + `INJECT_TICKS * `BOOT_TICK_DIV + 2;
    localparam int TIMEOUT_CYC  = 5 + 2 * BOOT_MAX_CYC + 2 * ERR_ROUNDS + INJECT_STEPS + 100;

    logic        clk40;
    logic        PRBS_reset;
    logic        inject_i;
    ccb_bus_t    ccb_rx_i;
    lane_vec_t   tx_reset_done = '0;
    lane_vec_t   rx_reset_done = '0;
    lane_vec_t   prbs_error_i;
    link_ctrl_t  link_ctrl_o;
    err_status_t err_status_o;
    lane_vec_t   led_fp_o;
    logic        bx0_o;

    logic [31:0] lcg_state = 32'h2501;
    logic        tx_armed  = 1'b0;
    logic        rx_armed  = 1'b0;
    int          tx_delay  = 0;
    int          rx_delay  = 0;
    logic        mon_en    = 1'b0;
    int          cycle_cnt = 0;
    int          err_cnt   = 0;

    prbs_link_top dut (
        .clk40           (clk40),
        .PRBS_reset      (PRBS_reset),
        .inject_i        (inject_i),
        .ccb_rx_i        (ccb_rx_i),
        .tx_reset_done_i (tx_reset_done),
        .rx_reset_done_i (rx_reset_done),
        .prbs_error_i    (prbs_error_i),
        .link_ctrl_o     (link_ctrl_o),
        .err_status_o    (err_status_o),
        .led_fp_o        (led_fp_o),
        .bx0_o           (bx0_o)
    );

    initial begin
        clk40 = 1'b0;
        forever #50 clk40 = ~clk40;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Ack latency in cycles, 2 to 15
    function automatic int xcvr_delay();
        logic [31:0] r;
        r = lcg_next();
        return 2 + int'(r[23:16] % 8'd14);
    endfunction

    // Strobe is active low, count resets held inactive
    function automatic ccb_bus_t ccb_word(input logic strobe_n, input int code);
        ccb_bus_t w;
        w = '1;
        w[`CCB_EVCNTRES_BIT-1:`CCB_CMD_LSB] = ccb_cmd_code_t'(code);
        w[`CCB_EVCNTRES_BIT] = 1'b0;
        w[`CCB_BCNTRES_BIT]  = 1'b0;
        w[`CCB_STROBE_BIT]   = strobe_n;
        return w;
    endfunction

    task automatic abort_run();
        err_cnt++;
        $display("Errors found");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Transceiver model, watchdog and handshake monitor

    // Done bits rise some cycles after the reset drops, fall when it returns
    always @(negedge clk40) begin
        if (PRBS_reset || link_ctrl_o.tx_reset !== '0) begin
            tx_reset_done <= '0;
            tx_armed      <= 1'b0;
        end else if (!tx_armed) begin
            tx_delay <= xcvr_delay();
            tx_armed <= 1'b1;
        end else if (tx_delay > 0) begin
            tx_delay <= tx_delay - 1;
        end else begin
            tx_reset_done <= ALL_LANES;
        end
        if (PRBS_reset || link_ctrl_o.rx_reset !== '0) begin
            rx_reset_done <= '0;
            rx_armed      <= 1'b0;
        end else if (!rx_armed) begin
            rx_delay <= xcvr_delay();
            rx_armed <= 1'b1;
        end else if (rx_delay > 0) begin
            rx_delay <= rx_delay - 1;
        end else begin
            rx_reset_done <= ALL_LANES;
        end
    end

    always @(posedge clk40) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("Timeout after %0d cycles waiting for the DUT", cycle_cnt);
            $display("Errors found");
            $fatal(1, "Simulation timed out");
        end
    end

    always @(negedge clk40) begin
        if (mon_en) begin
            // RX request only once every TX lane has acked
            if (link_ctrl_o.rx_reset != ALL_LANES && tx_reset_done != ALL_LANES) begin
                $display("RX reset released before all TX lanes reported reset done");
                abort_run();
            end
            // Checking phase only once every RX lane has acked
            if (!link_ctrl_o.prbs_cnt_reset && !link_ctrl_o.error_inject
                    && rx_reset_done != ALL_LANES) begin
                $display("PRBS checking entered before all RX lanes reported reset done");
                abort_run();
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic reset_phase();
        repeat (5) begin
            @(negedge clk40);
            compare("link_ctrl_o.tx_reset", link_ctrl_o.tx_reset, ALL_LANES);
            compare("link_ctrl_o.rx_reset", link_ctrl_o.rx_reset, ALL_LANES);
            compare("link_ctrl_o.prbs_cnt_reset", link_ctrl_o.prbs_cnt_reset, 1);
            compare("link_ctrl_o.error_inject", link_ctrl_o.error_inject, 0);
            compare("led_fp_o[7:4]", led_fp_o[7:4], 1);
        end
        PRBS_reset = 1'b0;
        mon_en     = 1'b1;
        @(negedge clk40);
        // TX request one cycle after release
        compare("link_ctrl_o.tx_reset", link_ctrl_o.tx_reset, 0);
        compare("link_ctrl_o.rx_reset", link_ctrl_o.rx_reset, ALL_LANES);
    endtask

    task automatic boot_link();
        int acked_len;
        acked_len = 0;
        while (link_ctrl_o.tx_reset !== '0) begin
            @(negedge clk40);
        end
        // Window opens in EN_RX_DONE
        while (!link_ctrl_o.error_inject) begin
            @(negedge clk40);
        end
        compare("link_ctrl_o.rx_reset", link_ctrl_o.rx_reset, 0);
        while (link_ctrl_o.error_inject) begin
            compare("link_ctrl_o.prbs_cnt_reset", link_ctrl_o.prbs_cnt_reset, 0);
            // Only cycles after the RX ack belong to the timed window
            if (rx_reset_done == ALL_LANES) begin
                acked_len++;
            end
            @(negedge clk40);
        end
        // Full inject window after the ack, plus at most one cycle of EN_RX_DONE
        if (acked_len < (`INJECT_TICKS - 1) * `BOOT_TICK_DIV + 1
                || acked_len > `INJECT_TICKS * `BOOT_TICK_DIV + 1) begin
            $display("Inject window lasted %0d cycles after the RX ack", acked_len);
            abort_run();
        end
        // Clear step, counters held, LED code 7
        compare("link_ctrl_o.prbs_cnt_reset", link_ctrl_o.prbs_cnt_reset, 1);
        compare("led_fp_o[7:4]", led_fp_o[7:4], 7);
        @(negedge clk40);
        compare("link_ctrl_o.prbs_cnt_reset", link_ctrl_o.prbs_cnt_reset, 0);
        compare("link_ctrl_o.error_inject", link_ctrl_o.error_inject, 0);
        compare("link_ctrl_o.rx_reset", link_ctrl_o.rx_reset, 0);
        compare("rx_reset_done_i", rx_reset_done, ALL_LANES);
        compare("err_status_o", err_status_o, 0);
    endtask

    task automatic count_errors();
        int          hits [`NUM_LANES];
        lane_vec_t   mask;
        lane_vec_t   exp_latched;
        err_status_t exp_status;
        logic [31:0] r;
        exp_latched = '0;
        for (int l = 0; l < `NUM_LANES; l++) begin
            hits[l] = 0;
        end
        for (int n = 0; n < ERR_ROUNDS; n++) begin
            r = lcg_next();
            // Lane 4 every round, so its counter wraps
            mask = r[23:16] | lane_vec_t'(1 << `MON_LANE_BASE);
            prbs_error_i = mask;
            exp_latched  = exp_latched | mask;
            for (int l = 0; l < `NUM_LANES; l++) begin
                if (mask[l]) begin
                    hits[l]++;
                end
            end
            @(negedge clk40);
            prbs_error_i = '0;
            @(negedge clk40);
        end
        exp_status.latched = exp_latched;
        for (int i = 0; i < `NUM_MON_LANES; i++) begin
            exp_status.counts[i] = err_cnt_t'(hits[`MON_LANE_BASE + i] % (1 << `ERR_CNT_W));
        end
        compare("err_status_o", err_status_o, exp_status);
    endtask

    task automatic decode_ccb();
        ccb_rx_i = ccb_word(1'b0, `CMD_BX0);
        @(negedge clk40);
        ccb_rx_i = ccb_word(1'b1, 0);
        compare("bx0_o", bx0_o, 0);
        @(negedge clk40);
        // Pulse two cycles after the word
        compare("bx0_o", bx0_o, 1);
        @(negedge clk40);
        compare("bx0_o", bx0_o, 0);
        // Strobe high, no command
        ccb_rx_i = ccb_word(1'b1, `CMD_BX0);
        repeat (4) begin
            @(negedge clk40);
            ccb_rx_i = ccb_word(1'b1, 0);
            compare("bx0_o", bx0_o, 0);
        end
        compare("link_ctrl_o.prbs_cnt_reset", link_ctrl_o.prbs_cnt_reset, 0);
    endtask

    task automatic follow_inject();
        logic [31:0] r;
        logic        prev_inject;
        prev_inject = 1'b0;
        for (int n = 0; n < INJECT_STEPS; n++) begin
            r = lcg_next();
            inject_i = r[24];
            #1;
            // Old value holds until the next rising edge
            compare("link_ctrl_o.error_inject", link_ctrl_o.error_inject, prev_inject);
            @(negedge clk40);
            compare("link_ctrl_o.error_inject", link_ctrl_o.error_inject, inject_i);
            compare("link_ctrl_o.prbs_cnt_reset", link_ctrl_o.prbs_cnt_reset, 0);
            prev_inject = inject_i;
        end
        inject_i = 1'b0;
        @(negedge clk40);
        compare("link_ctrl_o.error_inject", link_ctrl_o.error_inject, 0);
    endtask

    task automatic resync_link();
        ccb_rx_i = ccb_word(1'b0, `CMD_RESYNC);
        @(negedge clk40);
        ccb_rx_i = ccb_word(1'b1, 0);
        // Pulse two cycles after the word, FSM restarts on the next edge
        @(negedge clk40);
        compare("link_ctrl_o.tx_reset", link_ctrl_o.tx_reset, 0);
        @(negedge clk40);
        compare("link_ctrl_o.tx_reset", link_ctrl_o.tx_reset, ALL_LANES);
        compare("link_ctrl_o.rx_reset", link_ctrl_o.rx_reset, ALL_LANES);
        compare("link_ctrl_o.prbs_cnt_reset", link_ctrl_o.prbs_cnt_reset, 1);
        @(negedge clk40);
        compare("err_status_o", err_status_o, 0);
        boot_link();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        PRBS_reset   = 1'b1;
        inject_i     = 1'b0;
        ccb_rx_i     = ccb_word(1'b1, 0);
        prbs_error_i = '0;
        reset_phase();
        boot_link();
        count_errors();
        decode_ccb();
        follow_inject();
        resync_link();
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/prbs_link_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module prbs_link_top
    import prbs_link_pkg::*;
(
    input  wire            clk40,
    input  wire            PRBS_reset,
    input  wire            inject_i,
    input  wire ccb_bus_t  ccb_rx_i,
    input  wire lane_vec_t tx_reset_done_i,
    input  wire lane_vec_t rx_reset_done_i,
    input  wire lane_vec_t prbs_error_i,
    output link_ctrl_t     link_ctrl_o,
    output err_status_t    err_status_o,
    output lane_vec_t      led_fp_o,
    output logic           bx0_o
);

    logic        resync;
    boot_state_t boot_state;
    logic        boot_tick;

    // CCB commands
    ccb_cmd_decoder u_ccb_cmd_decoder (
        .clk40      (clk40),
        .PRBS_reset (PRBS_reset),
        .ccb_rx_i   (ccb_rx_i),
        .resync_o   (resync),
        .bx0_o      (bx0_o)
    );

    // Lane bring-up, restarted by TTC resync
    link_boot_sequencer u_link_boot_sequencer (
        .clk40           (clk40),
        .PRBS_reset      (PRBS_reset),
        .restart_i       (resync),
        .inject_i        (inject_i),
        .tx_reset_done_i (tx_reset_done_i),
        .rx_reset_done_i (rx_reset_done_i),
        .link_ctrl_o     (link_ctrl_o),
        .boot_state_o    (boot_state),
        .boot_tick_o     (boot_tick)
    );

    // Error flags and counters share the transceiver counter reset
    prbs_error_monitor u_prbs_error_monitor (
        .clk40            (clk40),
        .prbs_cnt_reset_i (link_ctrl_o.prbs_cnt_reset),
        .prbs_error_i     (prbs_error_i),
        .err_status_o     (err_status_o)
    );

    // Front panel
    led_status_mux u_led_status_mux (
        .clk40        (clk40),
        .PRBS_reset   (PRBS_reset),
        .boot_state_i (boot_state),
        .boot_tick_i  (boot_tick),
        .err_status_i (err_status_o),
        .led_fp_o     (led_fp_o)
    );

endmodule

`default_nettype wire

// ==== rtl/led_status_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "prbs_link_defines.svh"

module led_status_mux
    import prbs_link_pkg::*;
(
    input  wire              clk40,
    input  wire              PRBS_reset,
    input  wire boot_state_t boot_state_i,
    input  wire              boot_tick_i,
    input  wire err_status_t err_status_i,
    output lane_vec_t        led_fp_o
);

    logic       blink_q;
    logic [3:0] state_code;

    // Blinker toggles once per boot tick
    always_ff @(posedge clk40) begin
        if (PRBS_reset) begin
            blink_q <= 1'b0;
        end else if (boot_tick_i) begin
            blink_q <= ~blink_q;
        end
    end

    // Phase code shown on the upper nibble
    assign state_code = {1'b0, boot_state_i} + 4'd1;

    always_comb begin
        led_fp_o = '0;
        case (boot_state_i)
            // Phase code plus flags of the counted lanes
            PRBS_INJECT, PRBS_INJECT_CLEAR: begin
                led_fp_o[7:4] = state_code;
                led_fp_o[3:0] = err_status_i.latched[`MON_LANE_BASE +: `NUM_MON_LANES]
                              | {4{blink_q}};
            end
            // One LED pair per counter, counter 0 on top
            EN_PRBS_CK: begin
                for (int i = 0; i < `NUM_MON_LANES; i++) begin
                    led_fp_o[2*(`NUM_MON_LANES-1-i) +: 2] =
                        err_status_i.counts[i][`ERR_CNT_W-1 -: 2] | {2{blink_q}};
                end
            end
            default: begin
                led_fp_o[7:4] = state_code;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/prbs_error_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "prbs_link_defines.svh"

module prbs_error_monitor
    import prbs_link_pkg::*;
(
    input  wire            clk40,
    input  wire            prbs_cnt_reset_i,
    input  wire lane_vec_t prbs_error_i,
    output err_status_t    err_status_o
);

    logic [`NUM_MON_LANES-1:0] mon_err;
    logic [`NUM_MON_LANES-1:0] mon_err_q;
    logic [`NUM_MON_LANES-1:0] mon_rise;

    // Counted lanes only
    assign mon_err = prbs_error_i[`MON_LANE_BASE +: `NUM_MON_LANES];

    // Previous error level for edge detect
    always_ff @(posedge clk40) begin
        mon_err_q <= mon_err;
    end

    // A held error counts as one event
    assign mon_rise = mon_err & ~mon_err_q;

    ////////////////////////////////////////////////////////////////////////////
    // Sticky flags and event counters

    always_ff @(posedge clk40) begin
        if (prbs_cnt_reset_i) begin
            err_status_o <= '0;
        end else begin
            // Any error on a lane sticks until the next counter reset
            err_status_o.latched <= err_status_o.latched | prbs_error_i;
            for (int i = 0; i < `NUM_MON_LANES; i++) begin
                // Wraps at 64 events
                if (mon_rise[i]) begin
                    err_status_o.counts[i] <= err_status_o.counts[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/link_boot_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "prbs_link_defines.svh"

module link_boot_sequencer
    import prbs_link_pkg::*;
(
    input  wire            clk40,
    input  wire            PRBS_reset,
    input  wire            restart_i,
    input  wire            inject_i,
    input  wire lane_vec_t tx_reset_done_i,
    input  wire lane_vec_t rx_reset_done_i,
    output link_ctrl_t     link_ctrl_o,
    output boot_state_t    boot_state_o,
    output logic           boot_tick_o
);

    localparam int PRESC_W = $clog2(`BOOT_TICK_DIV);
    localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(`BOOT_TICK_DIV - 1);

    // All resets held, no inject
    localparam link_ctrl_t CTRL_RESET = '{
        tx_reset:       '1,
        rx_reset:       '1,
        prbs_cnt_reset: 1'b1,
        error_inject:   1'b0
    };

    logic [PRESC_W-1:0] presc_q;
    logic               tick;
    tick_cnt_t          wait_cnt;
    logic               settle_done;
    logic               inject_done;
    boot_state_t        state_q;
    boot_state_t        state_nxt;
    link_ctrl_t         ctrl_nxt;

    ////////////////////////////////////////////////////////////////////////////
    // Boot tick and wait counter

    always_ff @(posedge clk40) begin
        if (PRBS_reset || tick) begin
            presc_q <= '0;
        end else begin
            presc_q <= presc_q + 1'b1;
        end
    end

    // One cycle in every BOOT_TICK_DIV
    assign tick        = (presc_q == PRESC_LAST);
    assign boot_tick_o = tick;

    // Last tick of a timed state
    assign settle_done = tick && (wait_cnt == tick_cnt_t'(`SETTLE_TICKS - 1));
    assign inject_done = tick && (wait_cnt == tick_cnt_t'(`INJECT_TICKS - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Boot FSM

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            BOOT_RESET:        state_nxt = EN_TX;
            // TX reset released, let it settle
            EN_TX:             state_nxt = settle_done ? EN_TX_DONE : EN_TX;
            // Wait for every lane to ack
            EN_TX_DONE:        state_nxt = (&tx_reset_done_i) ? EN_RX : EN_TX_DONE;
            EN_RX:             state_nxt = settle_done ? EN_RX_DONE : EN_RX;
            EN_RX_DONE:        state_nxt = (&rx_reset_done_i) ? PRBS_INJECT : EN_RX_DONE;
            PRBS_INJECT:       state_nxt = inject_done ? PRBS_INJECT_CLEAR : PRBS_INJECT;
            PRBS_INJECT_CLEAR: state_nxt = EN_PRBS_CK;
            default:           state_nxt = EN_PRBS_CK;
        endcase
        // Resync wins from any phase
        if (restart_i) begin
            state_nxt = BOOT_RESET;
        end
    end

    // Controls follow the phase being entered, so they line up with it
    always_comb begin
        ctrl_nxt                = CTRL_RESET;
        ctrl_nxt.tx_reset       = '0;
        ctrl_nxt.rx_reset       = '0;
        case (state_nxt)
            BOOT_RESET: begin
                ctrl_nxt = CTRL_RESET;
            end
            // TX request is up, RX still held
            EN_TX, EN_TX_DONE: begin
                ctrl_nxt.rx_reset = '1;
            end
            // Forced error window while counters run
            EN_RX_DONE, PRBS_INJECT: begin
                ctrl_nxt.prbs_cnt_reset = 1'b0;
                ctrl_nxt.error_inject   = 1'b1;
            end
            EN_PRBS_CK: begin
                ctrl_nxt.prbs_cnt_reset = 1'b0;
                ctrl_nxt.error_inject   = inject_i;
            end
            // EN_RX and the clear step keep counters in reset
            default: begin
                ctrl_nxt.error_inject = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk40) begin
        if (PRBS_reset) begin
            state_q     <= BOOT_RESET;
            wait_cnt    <= '0;
            link_ctrl_o <= CTRL_RESET;
        end else begin
            state_q     <= state_nxt;
            link_ctrl_o <= ctrl_nxt;
            // Fresh count on every phase change
            if (state_nxt != state_q) begin
                wait_cnt <= '0;
            end else if (tick) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    assign boot_state_o = state_q;

endmodule

`default_nettype wire

// ==== rtl/ccb_cmd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "prbs_link_defines.svh"

module ccb_cmd_decoder
    import prbs_link_pkg::*;
(
    input  wire           clk40,
    input  wire           PRBS_reset,
    input  wire ccb_bus_t ccb_rx_i,
    output logic          resync_o,
    output logic          bx0_o
);

    ccb_bus_t              ccb_q;
    ccb_cmd_t              ccb_cmd;
    logic [`MAX_CMD_DEC:0] cmd_dec;

    ////////////////////////////////////////////////////////////////////////////
    // Input stage

    // Raw bus sampled once, close to the pins
    always_ff @(posedge clk40) begin
        ccb_q <= ccb_rx_i;
    end

    // Strobe is active low on the bus
    // Count resets pass through as they are
    always_comb begin
        ccb_cmd.cmd      = ccb_q[`CCB_EVCNTRES_BIT-1:`CCB_CMD_LSB];
        ccb_cmd.strobe   = ~ccb_q[`CCB_STROBE_BIT];
        ccb_cmd.evcntres = ccb_q[`CCB_EVCNTRES_BIT];
        ccb_cmd.bcntres  = ccb_q[`CCB_BCNTRES_BIT];
    end

    ////////////////////////////////////////////////////////////////////////////
    // One-hot command decode

    // One bit per code, valid only with the strobe
    always_ff @(posedge clk40) begin
        if (PRBS_reset) begin
            cmd_dec <= '0;
        end else begin
            for (int i = 0; i <= `MAX_CMD_DEC; i++) begin
                cmd_dec[i] <= ccb_cmd.strobe && (ccb_cmd.cmd == ccb_cmd_code_t'(i));
            end
        end
    end

    // Resync restarts the link bring-up
    assign resync_o = cmd_dec[`CMD_RESYNC];
    // Bunch crossing zero
    assign bx0_o    = cmd_dec[`CMD_BX0];

endmodule

`default_nettype wire

// ==== rtl/prbs_link_pkg.sv ====
`default_nettype none

`include "prbs_link_defines.svh"

package prbs_link_pkg;

    // One bit per serial lane
    typedef logic [`NUM_LANES-1:0] lane_vec_t;
    // Raw CCB bus as seen on the pins
    typedef logic [`CCB_W-1:0] ccb_bus_t;
    // Command field sits below the event count reset bit
    typedef logic [`CCB_EVCNTRES_BIT-`CCB_CMD_LSB-1:0] ccb_cmd_code_t;
    typedef logic [`ERR_CNT_W-1:0] err_cnt_t;
    // Boot wait counter in ticks
    typedef logic [5:0] tick_cnt_t;

    // Boot phases in bring-up order
    // Index plus one is the LED code
    typedef enum logic [2:0] {
        BOOT_RESET        = 3'd0,
        EN_TX             = 3'd1,
        EN_TX_DONE        = 3'd2,
        EN_RX             = 3'd3,
        EN_RX_DONE        = 3'd4,
        PRBS_INJECT       = 3'd5,
        PRBS_INJECT_CLEAR = 3'd6,
        EN_PRBS_CK        = 3'd7
    } boot_state_t;

    // CCB command after polarity restore
    typedef struct packed {
        ccb_cmd_code_t cmd;
        logic          strobe;
        logic          evcntres;
        logic          bcntres;
    } ccb_cmd_t;

    // Reset and inject controls toward the transceivers
    typedef struct packed {
        lane_vec_t tx_reset;
        lane_vec_t rx_reset;
        logic      prbs_cnt_reset;
        logic      error_inject;
    } link_ctrl_t;

    // Sticky flags and error event counters
    typedef struct packed {
        lane_vec_t                        latched;
        err_cnt_t [`NUM_MON_LANES-1:0]    counts;
    } err_status_t;

endpackage

`default_nettype wire

// ==== rtl/prbs_link_defines.svh ====
`ifndef PRBS_LINK_DEFINES_SVH
`define PRBS_LINK_DEFINES_SVH

// Serial lanes on the board
`define NUM_LANES 8

// CCB bus width and field positions
`define CCB_W            51
`define CCB_CMD_LSB      2
`define CCB_EVCNTRES_BIT 8
`define CCB_BCNTRES_BIT  9
`define CCB_STROBE_BIT   10

// TTC command codes
`define CMD_BX0    1
`define CMD_RESYNC 3
// Highest command code in the decode vector
`define MAX_CMD_DEC 50

// clk40 cycles per boot tick
`define BOOT_TICK_DIV 4
// Wait lengths in boot ticks
`define SETTLE_TICKS  3
`define INJECT_TICKS  31

// Error event counters on lanes 4 to 7
`define MON_LANE_BASE 4
`define NUM_MON_LANES 4
`define ERR_CNT_W     6

`endif
